/* filelist.f */
source/mtrap_pkg.sv
source/mtrap_csr_file.sv
source/mtrap_irq_prio.sv
source/mtrap_mtime.sv
source/mtrap_ctrl.sv
source/mtrap_top.sv
verif/mtrap_props.sv
verif/mtrap_tb.sv

/* verif/mtrap_tb.sv */
// Self-checking testbench for the machine trap unit; random CSR, trap, interrupt and timer runs.
`default_nettype none

module mtrap_tb import mtrap_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam xlen_t HARTID_VAL = 32'd5;
    localparam int N_CSR = 40;
    localparam int N_TRAP = 6;
    localparam int N_IRQ = 16;
    localparam int N_RET = 4;
    localparam int EXC_WAIT = 10;
    // Rough cycles per iteration of each test, plus the timer test and a margin.
    localparam int CYCLE_LIMIT = N_CSR * 12 + N_TRAP * 40 + N_IRQ * 50 + N_RET * 45 + 650;

    logic        clk;
    logic        rst;
    logic        csr_cyc;
    logic        csr_stb;
    logic        csr_we;
    csr_addr_t   csr_adr;
    xlen_t       csr_dat_w;
    xlen_t       csr_dat_r;
    logic        csr_ack;
    logic        csr_err;
    logic        tmr_cyc;
    logic        tmr_stb;
    logic        tmr_we;
    logic [1:0]  tmr_adr;
    xlen_t       tmr_dat_w;
    xlen_t       tmr_dat_r;
    logic        tmr_ack;
    logic        retire_valid;
    pc_t         retire_pc;
    logic        trap_req;
    logic [3:0]  trap_cause;
    logic        ret_req;
    logic [15:0] irq;
    logic        exc_valid;
    logic        exc_irq;
    cause_t      exc_cause;
    tvec_t       exc_tvec;
    pc_t         ret_epc;

    // CSR file model.
    logic        m_mie_b;
    logic        m_mpie_b;
    xlen_t       m_mie;
    xlen_t       m_mtvec;
    xlen_t       m_mscratch;
    xlen_t       m_mepc;
    xlen_t       m_mcause;

    csr_addr_t   known_adr [17];
    int          checks = 0;
    int          errors = 0;
    int          cycle_cnt = 0;
    int unsigned seed_ret;

    mtrap_top #(.HARTID(HARTID_VAL), .MTIME_DIV(4)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Run limit.
    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    initial begin
        wait (cycle_cnt >= CYCLE_LIMIT);
        $display("Timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
        $display("TEST FAIL");
        $finish;
    end

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    function automatic logic is_known(csr_addr_t a);
        foreach (known_adr[i]) begin
            if (known_adr[i] == a) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Lowest set bit wins.
    function automatic cause_t lowest_set(xlen_t v);
        for (int i = 0; i < 32; i++) begin
            if (v[i]) begin
                return cause_t'(i);
            end
        end
        return '0;
    endfunction

    // Expected read value. No line is pending while mip is read.
    function automatic xlen_t expect_read(csr_addr_t a);
        case (a)
            CSR_MSTATUS:  return (xlen_t'(m_mpie_b) << MSTATUS_MPIE_BIT)
                               | (xlen_t'(m_mie_b) << MSTATUS_MIE_BIT);
            // MXL 1, I and M set.
            CSR_MISA:     return 32'h4000_0000 | (32'd1 << 12) | (32'd1 << 8);
            CSR_MIE:      return m_mie;
            CSR_MTVEC:    return m_mtvec;
            CSR_MSCRATCH: return m_mscratch;
            CSR_MEPC:     return m_mepc;
            CSR_MCAUSE:   return m_mcause;
            CSR_MARCHID:  return MARCHID_VALUE;
            CSR_MHARTID:  return HARTID_VAL;
            default:      return '0;
        endcase
    endfunction

    task automatic model_write(input csr_addr_t a, input xlen_t d);
        case (a)
            CSR_MSTATUS: begin
                m_mie_b = d[MSTATUS_MIE_BIT];
                m_mpie_b = d[MSTATUS_MPIE_BIT];
            end
            CSR_MIE:      m_mie = d;
            CSR_MTVEC:    m_mtvec = {d[31:2], 2'b00};
            CSR_MSCRATCH: m_mscratch = d;
            CSR_MEPC:     m_mepc = {d[31:1], 1'b0};
            CSR_MCAUSE:   m_mcause = {d[31], 26'd0, d[4:0]};
            default: ;
        endcase
    endtask

    // Trap entry stacks MIE and records cause and pc.
    task automatic model_trap(input logic is_irq, input cause_t c, input pc_t pc);
        m_mpie_b = m_mie_b;
        m_mie_b = 1'b0;
        m_mepc = {pc, 1'b0};
        m_mcause = {is_irq, 26'd0, c};
    endtask

    // One Wishbone cycle on the CSR port; starts just after a rising edge.
    task automatic csr_access(input logic we, input csr_addr_t a, input xlen_t d,
                              output xlen_t rd, output logic ack, output logic err);
        csr_cyc <= 1'b1;
        csr_stb <= 1'b1;
        csr_we <= we;
        csr_adr <= a;
        csr_dat_w <= d;
        do begin
            @(negedge clk);
        end while (!(csr_ack || csr_err));
        rd = csr_dat_r;
        ack = csr_ack;
        err = csr_err;
        @(posedge clk);
        csr_cyc <= 1'b0;
        csr_stb <= 1'b0;
        csr_we <= 1'b0;
        @(posedge clk);
    endtask

    task automatic csr_write(input csr_addr_t a, input xlen_t d);
        xlen_t rd;
        logic  ack;
        logic  err;
        csr_access(1'b1, a, d, rd, ack, err);
        check_eq($sformatf("csr_ack write %h", a), ack, 1);
        if (ack) begin
            model_write(a, d);
        end
    endtask

    task automatic csr_read_check(input csr_addr_t a);
        xlen_t rd;
        logic  ack;
        logic  err;
        csr_access(1'b0, a, '0, rd, ack, err);
        check_eq($sformatf("csr_ack read %h", a), ack, 1);
        check_eq($sformatf("csr_dat_r %h", a), rd, expect_read(a));
    endtask

    // Timer port cycle; ack is due one cycle after the request.
    task automatic tmr_access(input logic we, input logic [1:0] a, input xlen_t d,
                              output xlen_t rd);
        int n;
        tmr_cyc <= 1'b1;
        tmr_stb <= 1'b1;
        tmr_we <= we;
        tmr_adr <= a;
        tmr_dat_w <= d;
        // First falling edge lies in the request cycle itself.
        @(negedge clk);
        n = 0;
        while (!tmr_ack) begin
            @(negedge clk);
            n++;
        end
        check_eq("tmr_ack latency", n, 1);
        rd = tmr_dat_r;
        @(posedge clk);
        tmr_cyc <= 1'b0;
        tmr_stb <= 1'b0;
        tmr_we <= 1'b0;
        @(posedge clk);
    endtask

    task automatic wait_exc(input int limit, output logic seen);
        seen = 1'b0;
        for (int i = 0; i < limit && !seen; i++) begin
            @(negedge clk);
            seen = exc_valid;
        end
    endtask

    // Synchronous trap; the report is due in the next cycle only.
    task automatic trap_and_check(input logic [3:0] c, input pc_t pc);
        trap_req <= 1'b1;
        trap_cause <= c;
        retire_pc <= pc;
        @(posedge clk);
        trap_req <= 1'b0;
        @(negedge clk);
        check_eq("exc_valid", exc_valid, 1);
        check_eq("exc_irq", exc_irq, 0);
        check_eq("exc_cause", exc_cause, {1'b0, c});
        check_eq("exc_tvec", exc_tvec, m_mtvec[31:2]);
        model_trap(1'b0, cause_t'(c), pc);
        @(negedge clk);
        check_eq("exc_valid pulse", exc_valid, 0);
        @(posedge clk);
    endtask

    task automatic test_random_csr();
        csr_addr_t a;
        logic      we;
        logic      exp_err;
        xlen_t     d;
        xlen_t     rd;
        logic      ack;
        logic      err;
        for (int n = 0; n < N_CSR; n++) begin
            if ($urandom % 20 < 17) begin
                a = known_adr[$urandom % 17];
            end else begin
                do begin
                    a = csr_addr_t'($urandom);
                end while (is_known(a));
            end
            we = $urandom % 2;
            d = $urandom;
            // Top two address bits 11 mark a read-only CSR.
            exp_err = !is_known(a) || (we && a[11:10] == 2'b11);
            csr_access(we, a, d, rd, ack, err);
            check_eq($sformatf("csr_err %h", a), err, exp_err);
            check_eq($sformatf("csr_ack %h", a), ack, !exp_err);
            if (ack && we) begin
                model_write(a, d);
                csr_read_check(a);
            end else if (ack) begin
                check_eq($sformatf("csr_dat_r %h", a), rd, expect_read(a));
            end
        end
        // ID registers.
        for (int i = 0; i < 5; i++) begin
            csr_read_check(CSR_MVENDORID + csr_addr_t'(i));
        end
    endtask

    task automatic test_trap();
        for (int n = 0; n < N_TRAP; n++) begin
            csr_write(CSR_MTVEC, $urandom);
            csr_write(CSR_MSTATUS, $urandom & 32'h88);
            trap_and_check(4'($urandom), pc_t'($urandom));
            csr_read_check(CSR_MEPC);
            csr_read_check(CSR_MCAUSE);
            csr_read_check(CSR_MSTATUS);
        end
    endtask

    task automatic test_irq();
        logic        en;
        logic        seen;
        logic        expect_exc;
        logic [15:0] pattern;
        xlen_t       enabled;
        cause_t      cause;
        pc_t         pc;
        for (int n = 0; n < N_IRQ; n++) begin
            en = ($urandom % 4) != 0;
            pattern = ($urandom % 8 == 0) ? 16'h0 : 16'($urandom);
            pc = pc_t'($urandom);
            csr_write(CSR_MIE, $urandom);
            csr_write(CSR_MTVEC, $urandom);
            csr_write(CSR_MSTATUS, xlen_t'(en) << MSTATUS_MIE_BIT);
            enabled = {pattern, 16'h0} & m_mie;
            cause = lowest_set(enabled);
            expect_exc = en && (enabled != '0);
            irq <= pattern;
            retire_valid <= 1'b1;
            retire_pc <= pc;
            wait_exc(EXC_WAIT, seen);
            check_eq("exc_valid taken", seen, expect_exc);
            if (seen && expect_exc) begin
                check_eq("exc_irq", exc_irq, 1);
                check_eq("exc_cause", exc_cause, cause);
                check_eq("exc_tvec", exc_tvec, m_mtvec[31:2]);
                model_trap(1'b1, cause, pc);
            end
            @(posedge clk);
            irq <= '0;
            retire_valid <= 1'b0;
            @(posedge clk);
            if (expect_exc) begin
                csr_read_check(CSR_MEPC);
                csr_read_check(CSR_MCAUSE);
                csr_read_check(CSR_MSTATUS);
            end
        end
    endtask

    task automatic test_ret();
        xlen_t d;
        for (int n = 0; n < N_RET; n++) begin
            csr_write(CSR_MSTATUS, xlen_t'($urandom % 2) << MSTATUS_MIE_BIT);
            trap_and_check(4'($urandom), pc_t'($urandom));
            d = $urandom;
            csr_write(CSR_MEPC, d);
            @(negedge clk);
            check_eq("ret_epc", ret_epc, d[31:1]);
            @(posedge clk);
            // MRET restores MIE from MPIE.
            ret_req <= 1'b1;
            @(posedge clk);
            ret_req <= 1'b0;
            m_mie_b = m_mpie_b;
            @(posedge clk);
            csr_read_check(CSR_MSTATUS);
            check_eq("ret_epc", ret_epc, d[31:1]);
        end
    endtask

    task automatic test_timer();
        xlen_t  lo;
        xlen_t  hi;
        mtime_t t1;
        mtime_t t2;
        logic   seen;
        pc_t    pc;
        tmr_access(1'b0, 2'd2, '0, lo);
        tmr_access(1'b0, 2'd3, '0, hi);
        check_eq("mtimecmp reset", {hi, lo}, 64'hffff_ffff_ffff_ffff);
        tmr_access(1'b0, 2'd0, '0, lo);
        tmr_access(1'b0, 2'd1, '0, hi);
        t1 = {hi, lo};
        repeat (5 + $urandom % 16) @(posedge clk);
        tmr_access(1'b0, 2'd0, '0, lo);
        tmr_access(1'b0, 2'd1, '0, hi);
        t2 = {hi, lo};
        // Samples lie at least eleven cycles apart, so mtime has ticked.
        check_eq("mtime advanced", t2 > t1, 1);
        // Timer interrupt with mtimecmp at 0.
        pc = pc_t'($urandom);
        csr_write(CSR_MIE, 32'd1 << IRQ_MTIMER);
        csr_write(CSR_MTVEC, $urandom);
        csr_write(CSR_MSTATUS, 32'd1 << MSTATUS_MIE_BIT);
        tmr_access(1'b1, 2'd3, '0, lo);
        tmr_access(1'b1, 2'd2, '0, lo);
        retire_valid <= 1'b1;
        retire_pc <= pc;
        wait_exc(EXC_WAIT, seen);
        check_eq("timer exc_valid", seen, 1);
        if (seen) begin
            check_eq("exc_irq", exc_irq, 1);
            check_eq("exc_cause", exc_cause, 5'd7);
            model_trap(1'b1, 5'd7, pc);
        end
        @(posedge clk);
        retire_valid <= 1'b0;
        @(posedge clk);
        csr_read_check(CSR_MCAUSE);
        // All ones in mtimecmp keeps the timer quiet.
        tmr_access(1'b1, 2'd2, 32'hffff_ffff, lo);
        tmr_access(1'b1, 2'd3, 32'hffff_ffff, lo);
        csr_write(CSR_MSTATUS, 32'd1 << MSTATUS_MIE_BIT);
        retire_valid <= 1'b1;
        wait_exc(EXC_WAIT, seen);
        check_eq("timer exc_valid quiet", seen, 0);
        @(posedge clk);
        retire_valid <= 1'b0;
        @(posedge clk);
    endtask

    task automatic end_test(input string name, input int errs_before);
        $display("%s finished, %0d errors", name, errors - errs_before);
    endtask

    initial begin
        int e0;
        int a_fails;
        seed_ret = $urandom(32'h243a);
        rst = 1'b1;
        csr_cyc = 1'b0;
        csr_stb = 1'b0;
        csr_we = 1'b0;
        csr_adr = '0;
        csr_dat_w = '0;
        tmr_cyc = 1'b0;
        tmr_stb = 1'b0;
        tmr_we = 1'b0;
        tmr_adr = '0;
        tmr_dat_w = '0;
        retire_valid = 1'b0;
        retire_pc = '0;
        trap_req = 1'b0;
        trap_cause = '0;
        ret_req = 1'b0;
        irq = '0;
        // Writable CSRs are 0 after reset.
        m_mie_b = 1'b0;
        m_mpie_b = 1'b0;
        m_mie = '0;
        m_mtvec = '0;
        m_mscratch = '0;
        m_mepc = '0;
        m_mcause = '0;
        known_adr = '{CSR_MSTATUS, CSR_MISA, CSR_MEDELEG, CSR_MIDELEG, CSR_MIE, CSR_MTVEC,
                      CSR_MSTATUSH, CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MIP,
                      CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID, CSR_MCONFIGPTR};
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_eq("exc_valid reset", exc_valid, 0);
        check_eq("csr_ack reset", csr_ack, 0);
        check_eq("csr_err reset", csr_err, 0);
        check_eq("tmr_ack reset", tmr_ack, 0);
        @(posedge clk);
        e0 = errors;
        test_random_csr();
        end_test("random csr access", e0);
        e0 = errors;
        test_trap();
        end_test("trap entry", e0);
        e0 = errors;
        test_irq();
        end_test("external interrupts", e0);
        e0 = errors;
        test_ret();
        end_test("mret", e0);
        e0 = errors;
        test_timer();
        end_test("machine timer", e0);
        a_fails = i_dut.i_ctrl.i_props.fail_cnt;
        $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, a_fails);
        if (errors == 0 && a_fails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/mtrap_props.sv */
// Concurrent checks on the trap controller; bound into every mtrap_ctrl instance.
`default_nettype none

module mtrap_props (
    input wire logic clk,
    input wire logic rst,
    input wire logic csr_cyc,
    input wire logic csr_stb,
    input wire logic csr_ack,
    input wire logic csr_err,
    input wire logic exc_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // Count of failed assertions.
    int fail_cnt = 0;

    // Exception report is a single-cycle pulse.
    a_exc_single: assert property (@(posedge clk) disable iff (rst) exc_valid |=> !exc_valid)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("exc_valid held for two cycles");
        end

    // Bus reply is either ack or err.
    a_ack_err_excl: assert property (@(posedge clk) disable iff (rst) !(csr_ack && csr_err))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("csr_ack and csr_err high together");
        end

    // A reply needs a live request.
    a_reply_needs_req: assert property (@(posedge clk) disable iff (rst)
        (csr_ack || csr_err) |-> (csr_cyc && csr_stb))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("CSR reply without cyc and stb");
        end

endmodule

bind mtrap_ctrl mtrap_props i_props (
    .clk, .rst, .csr_cyc, .csr_stb, .csr_ack, .csr_err, .exc_valid
);

`default_nettype wire

/* source/mtrap_top.sv */
// Top of the machine trap unit; connects controller, CSR file, interrupt logic and timer.
`default_nettype none

module mtrap_top import mtrap_pkg::*; #(
    parameter xlen_t HARTID    = '0,
    parameter int    MTIME_DIV = 1
) (
    input  wire logic        clk,
    input  wire logic        rst,
    // CSR Wishbone slave.
    input  wire logic        csr_cyc,
    input  wire logic        csr_stb,
    input  wire logic        csr_we,
    input  wire csr_addr_t   csr_adr,
    input  wire xlen_t       csr_dat_w,
    output xlen_t            csr_dat_r,
    output logic             csr_ack,
    output logic             csr_err,
    // Timer Wishbone slave.
    input  wire logic        tmr_cyc,
    input  wire logic        tmr_stb,
    input  wire logic        tmr_we,
    input  wire logic [1:0]  tmr_adr,
    input  wire xlen_t       tmr_dat_w,
    output xlen_t            tmr_dat_r,
    output logic             tmr_ack,
    // Core side.
    input  wire logic        retire_valid,
    input  wire pc_t         retire_pc,
    input  wire logic        trap_req,
    input  wire logic [3:0]  trap_cause,
    input  wire logic        ret_req,
    input  wire logic [15:0] irq,
    output logic             exc_valid,
    output logic             exc_irq,
    output cause_t           exc_cause,
    output tvec_t            exc_tvec,
    output pc_t              ret_epc
);

    logic   do_write;
    logic   do_trap;
    logic   do_irq;
    logic   do_ret;
    cause_t commit_cause;
    logic   csr_exists;
    logic   csr_rdonly;
    logic   mstatus_mie;
    xlen_t  mie;
    tvec_t  mtvec;
    xlen_t  irq_pending;
    logic   irq_any;
    cause_t irq_cause;
    logic   mtimer_irq;

    mtrap_ctrl i_ctrl (
        .clk, .rst,
        .csr_cyc, .csr_stb, .csr_exists, .csr_rdonly, .csr_we,
        .trap_req, .trap_cause, .retire_valid, .irq_any, .irq_cause,
        .mstatus_mie, .mtvec, .ret_req,
        .csr_ack, .csr_err,
        .do_write, .do_trap, .do_irq, .do_ret, .commit_cause,
        .exc_valid, .exc_irq, .exc_cause, .exc_tvec
    );

    // MRET target is always the live mepc.
    mtrap_csr_file #(.HARTID(HARTID)) i_csr_file (
        .clk, .rst,
        .csr_adr, .csr_dat_w,
        .do_write, .do_trap, .do_irq, .do_ret, .commit_cause,
        .retire_pc, .irq_pending,
        .csr_dat_r, .csr_exists, .csr_rdonly,
        .mstatus_mie, .mie, .mtvec, .mepc(ret_epc)
    );

    mtrap_irq_prio i_irq_prio (
        .clk, .rst,
        .irq, .mtimer_irq, .mie,
        .irq_pending, .irq_any, .irq_cause
    );

    mtrap_mtime #(.MTIME_DIV(MTIME_DIV)) i_mtime (
        .clk, .rst,
        .tmr_cyc, .tmr_stb, .tmr_we, .tmr_adr, .tmr_dat_w,
        .tmr_dat_r, .tmr_ack, .mtimer_irq
    );

endmodule

`default_nettype wire

/* source/mtrap_ctrl.sv */
// Trap controller FSM; arbitrates traps, interrupts, MRET and CSR bus access.
`default_nettype none

module mtrap_ctrl import mtrap_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    // CSR bus request and decode flags.
    input  wire logic       csr_cyc,
    input  wire logic       csr_stb,
    input  wire logic       csr_exists,
    input  wire logic       csr_rdonly,
    input  wire logic       csr_we,
    // Core events.
    input  wire logic       trap_req,
    input  wire logic [3:0] trap_cause,
    input  wire logic       retire_valid,
    input  wire logic       irq_any,
    input  wire cause_t     irq_cause,
    input  wire logic       mstatus_mie,
    input  wire tvec_t      mtvec,
    input  wire logic       ret_req,
    output logic            csr_ack,
    output logic            csr_err,
    // Commit strobes to the CSR file.
    output logic            do_write,
    output logic            do_trap,
    output logic            do_irq,
    output logic            do_ret,
    output cause_t          commit_cause,
    // One-cycle exception report.
    output logic            exc_valid,
    output logic            exc_irq,
    output cause_t          exc_cause,
    output tvec_t           exc_tvec
);

    localparam int SETTLE_W = $clog2(IRQ_SETTLE_CYCLES + 1);

    ctrl_state_t         state;
    ctrl_state_t         state_next;
    logic [SETTLE_W-1:0] settle_cnt;
    logic                irq_en;
    logic                csr_req;
    logic                csr_ok;
    logic                events_open;
    logic                take_csr;

    assign csr_req = csr_cyc && csr_stb;
    // Unknown address, or a write to a read-only ID.
    assign csr_ok = csr_exists && !(csr_we && csr_rdonly);

    // Core events are taken in idle and in the bus turnaround cycle.
    assign events_open = (state == st_idle) || (state == st_settle);
    assign irq_en = mstatus_mie && (settle_cnt == SETTLE_W'(IRQ_SETTLE_CYCLES));

    // Trap beats interrupt, both beat MRET and the bus.
    assign do_trap = events_open && trap_req;
    assign do_irq = events_open && !trap_req && retire_valid && irq_any && irq_en;
    assign do_ret = events_open && !trap_req && !do_irq && ret_req;
    assign take_csr = (state == st_idle) && csr_req && !trap_req && !do_irq && !ret_req;
    assign commit_cause = do_trap ? cause_t'(trap_cause) : irq_cause;

    // Bus reply in the cycle after the request is accepted.
    assign csr_ack = (state == st_csr_ack) && csr_req && csr_ok;
    assign csr_err = (state == st_csr_ack) && csr_req && !csr_ok;
    assign do_write = csr_ack && csr_we;

    always_comb begin
        state_next = st_idle;
        case (state)
            st_idle, st_settle: begin
                if (do_trap || do_irq) begin
                    state_next = st_trap;
                end else if (take_csr) begin
                    state_next = st_csr_ack;
                end
            end
            // Master drops stb after ack.
            st_csr_ack: state_next = st_settle;
            default:    state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            exc_valid <= 1'b0;
        end else begin
            state <= state_next;
            exc_valid <= do_trap || do_irq;
        end
    end

    // Restarts while MIE is low, saturates at the settle count.
    always_ff @(posedge clk) begin
        if (rst || !mstatus_mie) begin
            settle_cnt <= '0;
        end else if (!irq_en) begin
            settle_cnt <= settle_cnt + 1'b1;
        end
    end

    // Report payload, captured at trap entry.
    always_ff @(posedge clk) begin
        if (do_trap || do_irq) begin
            exc_irq <= do_irq;
            exc_cause <= commit_cause;
            exc_tvec <= mtvec;
        end
    end

endmodule

`default_nettype wire

/* source/mtrap_mtime.sv */
// Machine timer with mtime and mtimecmp behind a Wishbone classic slave.
`default_nettype none

module mtrap_mtime import mtrap_pkg::*; #(
    parameter int MTIME_DIV = 1
) (
    input  wire logic       clk,
    input  wire logic       rst,
    // Timer bus, word index in tmr_adr.
    input  wire logic       tmr_cyc,
    input  wire logic       tmr_stb,
    input  wire logic       tmr_we,
    input  wire logic [1:0] tmr_adr,
    input  wire xlen_t      tmr_dat_w,
    output xlen_t           tmr_dat_r,
    output logic            tmr_ack,
    output logic            mtimer_irq
);

    // Prescaler width, at least one bit.
    localparam int DIV_W = (MTIME_DIV > 1) ? $clog2(MTIME_DIV) : 1;

    logic [DIV_W-1:0] presc;
    logic             tick;
    logic             req_new;
    logic             wr_en;
    mtime_t           mtime;
    mtime_t           mtime_next;
    mtime_t           mtimecmp;
    xlen_t            rd_word;

    assign tick = (presc == DIV_W'(MTIME_DIV - 1));
    // A held request is served once; ack ends it.
    assign req_new = tmr_cyc && tmr_stb && !tmr_ack;
    assign wr_en = req_new && tmr_we;

    // Word writes override the increment.
    always_comb begin
        mtime_next = tick ? mtime + 64'd1 : mtime;
        if (wr_en && tmr_adr == 2'd0) begin
            mtime_next[31:0] = tmr_dat_w;
        end
        if (wr_en && tmr_adr == 2'd1) begin
            mtime_next[63:32] = tmr_dat_w;
        end
    end

    always_comb begin
        case (tmr_adr)
            2'd0:    rd_word = mtime[31:0];
            2'd1:    rd_word = mtime[63:32];
            2'd2:    rd_word = mtimecmp[31:0];
            default: rd_word = mtimecmp[63:32];
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            presc <= '0;
            mtime <= '0;
            mtimecmp <= MTIMECMP_RESET;
            tmr_ack <= 1'b0;
        end else begin
            presc <= tick ? '0 : presc + 1'b1;
            mtime <= mtime_next;
            tmr_ack <= req_new;
            if (wr_en && tmr_adr == 2'd2) begin
                mtimecmp[31:0] <= tmr_dat_w;
            end
            if (wr_en && tmr_adr == 2'd3) begin
                mtimecmp[63:32] <= tmr_dat_w;
            end
        end
    end

    // Read data, valid with ack.
    always_ff @(posedge clk) begin
        if (req_new) begin
            tmr_dat_r <= rd_word;
        end
    end

    // Level interrupt straight from the registers.
    assign mtimer_irq = (mtime >= mtimecmp);

endmodule

`default_nettype wire

/* source/mtrap_irq_prio.sv */
// Registers the interrupt lines and picks the lowest-numbered enabled pending interrupt.
`default_nettype none

module mtrap_irq_prio import mtrap_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    // External lines, mapped to causes 16 to 31.
    input  wire logic [15:0] irq,
    input  wire logic        mtimer_irq,
    input  wire xlen_t       mie,
    output xlen_t            irq_pending,
    output logic             irq_any,
    output cause_t           irq_cause
);

    xlen_t irq_masked;

    // One register stage from the lines to the pending bits.
    always_ff @(posedge clk) begin
        if (rst) begin
            irq_pending <= '0;
        end else begin
            irq_pending <= '0;
            irq_pending[IRQ_EXT_LO +: 16] <= irq;
            irq_pending[IRQ_MTIMER] <= mtimer_irq;
        end
    end

    assign irq_masked = irq_pending & mie;
    assign irq_any = |irq_masked;

    // Scan from the top so the lowest set bit wins.
    always_comb begin
        irq_cause = '0;
        for (int i = 31; i >= 0; i--) begin
            if (irq_masked[i]) begin
                irq_cause = cause_t'(i);
            end
        end
    end

endmodule

`default_nettype wire

/* source/mtrap_csr_file.sv */
// Machine CSR storage with address decode; updated by bus writes, trap entry and MRET.
`default_nettype none

module mtrap_csr_file import mtrap_pkg::*; #(
    parameter xlen_t HARTID = '0
) (
    input  wire logic clk,
    input  wire logic rst,
    // Bus side address and write data.
    input  wire csr_addr_t csr_adr,
    input  wire xlen_t     csr_dat_w,
    // Commit strobes from the controller.
    input  wire logic   do_write,
    input  wire logic   do_trap,
    input  wire logic   do_irq,
    input  wire logic   do_ret,
    input  wire cause_t commit_cause,
    input  wire pc_t    retire_pc,
    input  wire xlen_t  irq_pending,
    // Read side.
    output xlen_t     csr_dat_r,
    output logic      csr_exists,
    output logic      csr_rdonly,
    // State used by the controller and interrupt logic.
    output logic      mstatus_mie,
    output xlen_t     mie,
    output tvec_t     mtvec,
    output pc_t       mepc
);

    logic   mstatus_mpie;
    xlen_t  mscratch;
    logic   mcause_int;
    cause_t mcause_no;
    xlen_t  mstatus_val;

    // Only MIE and MPIE are implemented in mstatus.
    always_comb begin
        mstatus_val = '0;
        mstatus_val[MSTATUS_MIE_BIT] = mstatus_mie;
        mstatus_val[MSTATUS_MPIE_BIT] = mstatus_mpie;
    end

    // Read decode.
    always_comb begin
        csr_exists = 1'b1;
        csr_rdonly = 1'b0;
        csr_dat_r = '0;
        case (csr_adr)
            CSR_MSTATUS:    csr_dat_r = mstatus_val;
            CSR_MISA:       csr_dat_r = MISA_VALUE;
            CSR_MEDELEG:    csr_dat_r = '0;
            CSR_MIDELEG:    csr_dat_r = '0;
            CSR_MIE:        csr_dat_r = mie;
            CSR_MTVEC:      csr_dat_r = {mtvec, 2'b00};
            CSR_MSTATUSH:   csr_dat_r = '0;
            // Pending lines, masked by the enables.
            CSR_MIP:        csr_dat_r = irq_pending & mie;
            CSR_MSCRATCH:   csr_dat_r = mscratch;
            CSR_MEPC:       csr_dat_r = {mepc, 1'b0};
            CSR_MCAUSE:     csr_dat_r = {mcause_int, 26'd0, mcause_no};
            CSR_MTVAL:      csr_dat_r = '0;
            CSR_MVENDORID:  csr_rdonly = 1'b1;
            CSR_MARCHID: begin
                csr_rdonly = 1'b1;
                csr_dat_r = MARCHID_VALUE;
            end
            CSR_MIMPID:     csr_rdonly = 1'b1;
            CSR_MHARTID: begin
                csr_rdonly = 1'b1;
                csr_dat_r = HARTID;
            end
            CSR_MCONFIGPTR: csr_rdonly = 1'b1;
            default:        csr_exists = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_mie <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie <= '0;
            mtvec <= '0;
            mscratch <= '0;
            mepc <= '0;
            mcause_int <= 1'b0;
            mcause_no <= '0;
        end else if (do_trap || do_irq) begin
            // Trap entry stacks MIE and disables interrupts.
            mstatus_mpie <= mstatus_mie;
            mstatus_mie <= 1'b0;
            mepc <= retire_pc;
            mcause_int <= do_irq;
            mcause_no <= commit_cause;
        end else if (do_write) begin
            case (csr_adr)
                CSR_MSTATUS: begin
                    mstatus_mie <= csr_dat_w[MSTATUS_MIE_BIT];
                    mstatus_mpie <= csr_dat_w[MSTATUS_MPIE_BIT];
                end
                CSR_MIE:      mie <= csr_dat_w;
                CSR_MTVEC:    mtvec <= csr_dat_w[31:2];
                CSR_MSCRATCH: mscratch <= csr_dat_w;
                CSR_MEPC:     mepc <= csr_dat_w[31:1];
                CSR_MCAUSE: begin
                    mcause_int <= csr_dat_w[31];
                    mcause_no <= csr_dat_w[4:0];
                end
                // Other registers ignore writes.
                default: ;
            endcase
        end else if (do_ret) begin
            // MRET.
            mstatus_mie <= mstatus_mpie;
        end
    end

endmodule

`default_nettype wire

/* source/mtrap_pkg.sv */
// Shared types, CSR addresses, interrupt numbers and reset values for the machine trap unit.
`default_nettype none

package mtrap_pkg;

    // Machine data word.
    typedef logic [31:0] xlen_t;
    // CSR address.
    typedef logic [11:0] csr_addr_t;
    // Trap or interrupt cause number.
    typedef logic [4:0]  cause_t;
    // Instruction address, bit 0 dropped.
    typedef logic [30:0] pc_t;
    // Trap vector base, low two bits dropped.
    typedef logic [29:0] tvec_t;
    // Machine timer value.
    typedef logic [63:0] mtime_t;

    // Machine CSR addresses.
    localparam csr_addr_t CSR_MSTATUS    = 12'h300;
    localparam csr_addr_t CSR_MISA       = 12'h301;
    localparam csr_addr_t CSR_MEDELEG    = 12'h302;
    localparam csr_addr_t CSR_MIDELEG    = 12'h303;
    localparam csr_addr_t CSR_MIE        = 12'h304;
    localparam csr_addr_t CSR_MTVEC      = 12'h305;
    localparam csr_addr_t CSR_MSTATUSH   = 12'h310;
    localparam csr_addr_t CSR_MSCRATCH   = 12'h340;
    localparam csr_addr_t CSR_MEPC       = 12'h341;
    localparam csr_addr_t CSR_MCAUSE     = 12'h342;
    localparam csr_addr_t CSR_MTVAL      = 12'h343;
    localparam csr_addr_t CSR_MIP        = 12'h344;
    // Read-only ID registers.
    localparam csr_addr_t CSR_MVENDORID  = 12'hf11;
    localparam csr_addr_t CSR_MARCHID    = 12'hf12;
    localparam csr_addr_t CSR_MIMPID     = 12'hf13;
    localparam csr_addr_t CSR_MHARTID    = 12'hf14;
    localparam csr_addr_t CSR_MCONFIGPTR = 12'hf15;

    // Interrupt numbers.
    localparam int IRQ_MTIMER = 7;
    localparam int IRQ_EXT_LO = 16;

    // mstatus bit positions.
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;

    // Constant ID and reset values.
    localparam xlen_t  MARCHID_VALUE  = 32'd37;
    // RV32 with I and M, no C.
    localparam xlen_t  MISA_VALUE     = 32'h4000_1100;
    localparam mtime_t MTIMECMP_RESET = '1;

    // Cycles MIE must be stable before an interrupt is taken.
    localparam int IRQ_SETTLE_CYCLES = 2;

    // Controller states.
    typedef enum logic [1:0] {
        st_idle,
        st_csr_ack,
        st_trap,
        st_settle
    } ctrl_state_t;

endpackage

`default_nettype wire
